// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

	// instruction RAM size, in words, as a power of two
	localparam int IWIDTH = 14;
	localparam int IDEPTH = 1 << IWIDTH;

	// word PC, bits 31:2 of the byte address
	typedef logic [29:0] pc_t;

	// one instruction word
	typedef logic [31:0] inst_t;

	// word address into the instruction RAM
	typedef logic [IWIDTH-1:0] iaddr_t;

	// addi x0,x0,0
	// shown to decode after reset and after a pipeline flush
	localparam inst_t NOP_INST = 32'h0000_0013;

endpackage

// ==== logic/pc_sequencer.sv ====
`timescale 1ns/1ns

module pc_sequencer
	import fetch_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	// start from the monitor side
	input  logic i_pc_start,
	input  pc_t  i_start_adr,
	// pipeline back-pressure
	input  logic i_stall,
	// redirect requests from execute
	input  logic i_jmp_cond,
	input  pc_t  i_jmp_adr,
	input  logic i_ecall,
	input  logic i_interrupt,
	input  logic i_exception,
	input  logic i_mret,
	input  logic i_sret,
	// trap vector and return addresses from the CSRs
	input  pc_t  i_mtvec,
	input  pc_t  i_mepc,
	input  pc_t  i_sepc,
	// fetch PC and delayed jump flag
	output pc_t  o_pc_if,
	output logic o_post_jump
);

	logic trap;           // ecall, interrupt or exception
	logic jump_cmd;       // jump or any return
	logic post_trap;      // trap seen last cycle
	logic redirect;       // a redirect that is not masked
	pc_t  redirect_adr;
	pc_t  pc_if;
	pc_t  pc_next;
	logic post_jump;

	assign trap     = i_ecall | i_interrupt | i_exception;
	assign jump_cmd = i_jmp_cond | i_mret | i_sret;

	// anything but a trap right after a trap belongs to a squashed instruction
	assign redirect = trap | (jump_cmd & ~post_trap);

	// target select, trap first then mret, sret, jump
	always_comb begin
		if (trap) begin
			redirect_adr = i_mtvec;
		end else if (i_mret) begin
			redirect_adr = i_mepc;
		end else if (i_sret) begin
			redirect_adr = i_sepc;
		end else begin
			redirect_adr = i_jmp_adr;
		end
	end

	// next PC in start, stall, redirect, increment order
	always_comb begin
		if (i_pc_start) begin
			pc_next = i_start_adr;
		end else if (i_stall) begin
			pc_next = pc_if;      // hold
		end else if (redirect) begin
			pc_next = redirect_adr;
		end else begin
			pc_next = pc_if + 30'd1;   // next word
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_if <= '0;
		end else begin
			pc_if <= pc_next;
		end
	end

	// trap shadow, one cycle long
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			post_trap <= 1'b0;
		end else begin
			post_trap <= trap;
		end
	end

	// jump or return condition, one cycle later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			post_jump <= 1'b0;
		end else begin
			post_jump <= jump_cmd;
		end
	end

	assign o_pc_if     = pc_if;
	assign o_post_jump = post_jump;

endmodule

// ==== logic/inst_ram.sv ====
`timescale 1ns/1ns

module inst_ram
	import fetch_pkg::*;
(
	input  logic   clk,
	// fetch side read address
	input  iaddr_t i_pc_addr,
	// monitor port
	input  logic   i_read_sel,   // monitor owns the read port when high
	input  iaddr_t i_mon_radr,
	input  iaddr_t i_wadr,
	input  inst_t  i_wdata,
	input  logic   i_wen,
	// read data, one clock after the address
	output inst_t  o_rdata
);

	inst_t  mem [IDEPTH];
	iaddr_t rd_adr;
	inst_t  rdata;

	// monitor readback or normal fetch
	assign rd_adr = i_read_sel ? i_mon_radr : i_pc_addr;

	// single write port, loaded by the monitor
	always_ff @(posedge clk) begin
		if (i_wen) begin
			mem[i_wadr] <= i_wdata;
		end
	end

	// synchronous read
	always_ff @(posedge clk) begin
		rdata <= mem[rd_adr];
	end

	assign o_rdata = rdata;

endmodule

// ==== logic/fetch_hold.sv ====
`timescale 1ns/1ns

module fetch_hold
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  i_stall,
	input  logic  i_rst_pipe,    // one-cycle flush strobe
	input  pc_t   i_pc_if,
	input  inst_t i_ram_rdata,   // word at the previous pc_if
	// to decode
	output pc_t   o_pc_id,
	output inst_t o_inst_id
);

	pc_t   pc_id;
	logic  stall_dly;     // i_stall, one cycle late
	logic  stall_1shot;   // first cycle of a stall
	logic  flushed;
	inst_t inst_hold;
	inst_t inst_id;

	assign stall_1shot = i_stall & ~stall_dly;

	// decode PC follows the fetch PC by one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_id <= '0;
		end else if (i_rst_pipe) begin
			pc_id <= '0;
		end else if (!i_stall) begin
			pc_id <= i_pc_if;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stall_dly <= 1'b0;
		end else begin
			stall_dly <= i_stall;
		end
	end

	// NOP shown until the next edge without a stall
	// also set out of reset so decode starts on a NOP
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flushed <= 1'b1;
		end else if (i_rst_pipe) begin
			flushed <= 1'b1;
		end else if (!i_stall) begin
			flushed <= 1'b0;
		end
	end

	// the RAM moves on to pc_if after the first stall edge,
	// so the word for pc_id has to be caught on that edge
	always_ff @(posedge clk) begin
		if (stall_1shot) begin
			inst_hold <= i_ram_rdata;
		end
	end

	always_comb begin
		if (flushed) begin
			inst_id = NOP_INST;
		end else if (stall_dly) begin
			inst_id = inst_hold;     // held across the stall
		end else begin
			inst_id = i_ram_rdata;   // live RAM word
		end
	end

	assign o_pc_id   = pc_id;
	assign o_inst_id = inst_id;

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit
	import fetch_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	// pipeline control
	input  logic   i_stall,
	input  logic   i_rst_pipe,
	// redirects from execute and the CSRs
	input  logic   i_jmp_cond,
	input  pc_t    i_jmp_adr,
	input  logic   i_ecall,
	input  logic   i_interrupt,
	input  logic   i_exception,
	input  logic   i_mret,
	input  logic   i_sret,
	input  pc_t    i_mtvec,
	input  pc_t    i_mepc,
	input  pc_t    i_sepc,
	// start
	input  logic   i_pc_start,
	input  pc_t    i_start_adr,
	// monitor port
	input  iaddr_t i_ram_radr,
	input  iaddr_t i_ram_wadr,
	input  inst_t  i_ram_wdata,
	input  logic   i_ram_wen,
	input  logic   i_read_sel,
	// to decode
	output inst_t  o_inst_id,
	output pc_t    o_pc_id,
	// status and monitor readback
	output logic [31:0] o_pc_data,  // byte address of pc_if
	output logic   o_post_jump,
	output inst_t  o_ram_rdata
);

	pc_t   pc_if;
	inst_t ram_rdata;

	pc_sequencer u_pc_sequencer (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_pc_start  (i_pc_start),
		.i_start_adr (i_start_adr),
		.i_stall     (i_stall),
		.i_jmp_cond  (i_jmp_cond),
		.i_jmp_adr   (i_jmp_adr),
		.i_ecall     (i_ecall),
		.i_interrupt (i_interrupt),
		.i_exception (i_exception),
		.i_mret      (i_mret),
		.i_sret      (i_sret),
		.i_mtvec     (i_mtvec),
		.i_mepc      (i_mepc),
		.i_sepc      (i_sepc),
		.o_pc_if     (pc_if),
		.o_post_jump (o_post_jump)
	);

	inst_ram u_inst_ram (
		.clk        (clk),
		.i_pc_addr  (pc_if[IWIDTH-1:0]),   // RAM sees the low word bits only
		.i_read_sel (i_read_sel),
		.i_mon_radr (i_ram_radr),
		.i_wadr     (i_ram_wadr),
		.i_wdata    (i_ram_wdata),
		.i_wen      (i_ram_wen),
		.o_rdata    (ram_rdata)
	);

	fetch_hold u_fetch_hold (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_stall     (i_stall),
		.i_rst_pipe  (i_rst_pipe),
		.i_pc_if     (pc_if),
		.i_ram_rdata (ram_rdata),
		.o_pc_id     (o_pc_id),
		.o_inst_id   (o_inst_id)
	);

	assign o_pc_data   = {pc_if, 2'b00};
	assign o_ram_rdata = ram_rdata;

endmodule

// ==== sim/tb_fetch_unit.sv ====
`timescale 1ns/1ns

module tb_fetch_unit
	import fetch_pkg::*;
();

	localparam pc_t START_PC = 30'h0000_0040;
	localparam pc_t MTVEC    = 30'h0000_3100;
	localparam pc_t MEPC     = 30'h0000_1200;
	localparam pc_t SEPC     = 30'h0000_2300;
	localparam pc_t JMP_A    = 30'h0000_02a0;
	localparam pc_t JMP_B    = 30'h0001_4abc;   // above the RAM, wraps onto 0x0abc
	localparam pc_t JMP_C    = 30'h0000_0c00;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        i_stall;
	logic        i_rst_pipe;
	logic        i_jmp_cond;
	pc_t         i_jmp_adr;
	logic        i_ecall;
	logic        i_interrupt;
	logic        i_exception;
	logic        i_mret;
	logic        i_sret;
	pc_t         i_mtvec;
	pc_t         i_mepc;
	pc_t         i_sepc;
	logic        i_pc_start;
	pc_t         i_start_adr;
	iaddr_t      i_ram_radr;
	iaddr_t      i_ram_wadr;
	inst_t       i_ram_wdata;
	logic        i_ram_wen;
	logic        i_read_sel;
	inst_t       o_inst_id;
	pc_t         o_pc_id;
	logic [31:0] o_pc_data;
	logic        o_post_jump;
	inst_t       o_ram_rdata;

	// expected fetch state
	pc_t   m_pc_if;
	pc_t   m_pc_id;
	logic  m_flush;
	logic  m_trap_dly;    // trap seen at the last edge
	logic  m_post_jump;
	logic  m_trap;
	logic  m_jump_cmd;
	inst_t exp_inst;

	logic  inst_on = 1'b0;   // program loaded and fetch started
	logic  have_prev = 1'b0;
	logic  edge_stall;
	logic  edge_flush;
	pc_t   prev_pc_id;
	inst_t prev_inst;

	always #2 clk = ~clk;

	fetch_unit u_fetch_unit (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_stall     (i_stall),
		.i_rst_pipe  (i_rst_pipe),
		.i_jmp_cond  (i_jmp_cond),
		.i_jmp_adr   (i_jmp_adr),
		.i_ecall     (i_ecall),
		.i_interrupt (i_interrupt),
		.i_exception (i_exception),
		.i_mret      (i_mret),
		.i_sret      (i_sret),
		.i_mtvec     (i_mtvec),
		.i_mepc      (i_mepc),
		.i_sepc      (i_sepc),
		.i_pc_start  (i_pc_start),
		.i_start_adr (i_start_adr),
		.i_ram_radr  (i_ram_radr),
		.i_ram_wadr  (i_ram_wadr),
		.i_ram_wdata (i_ram_wdata),
		.i_ram_wen   (i_ram_wen),
		.i_read_sel  (i_read_sel),
		.o_inst_id   (o_inst_id),
		.o_pc_id     (o_pc_id),
		.o_pc_data   (o_pc_data),
		.o_post_jump (o_post_jump),
		.o_ram_rdata (o_ram_rdata)
	);

	// program word for a RAM address
	function automatic inst_t pattern_word(input iaddr_t adr);
		return {{(32-IWIDTH){1'b0}}, adr} ^ 32'ha5a5_0000;
	endfunction

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "simulation stopped");
	endtask

	task automatic value_error(input string what);
		$display("ERR %0t ns %s", $time, what);
		abort_run();
	endtask

	task automatic timeout_error(input string what);
		$display("timed out at %0t ns waiting for %s", $time, what);
		abort_run();
	endtask

	assign m_trap     = i_ecall | i_interrupt | i_exception;
	assign m_jump_cmd = i_jmp_cond | i_mret | i_sret;
	assign exp_inst   = m_flush ? NOP_INST : pattern_word(m_pc_id[IWIDTH-1:0]);

	// start, stall, redirect, increment; trap before mret before sret before jump
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_pc_if     <= '0;
			m_pc_id     <= '0;
			m_flush     <= 1'b1;
			m_trap_dly  <= 1'b0;
			m_post_jump <= 1'b0;
		end else begin
			if (i_pc_start) begin
				m_pc_if <= i_start_adr;
			end else if (!i_stall) begin
				if (m_trap) begin
					m_pc_if <= i_mtvec;
				end else if (m_jump_cmd && !m_trap_dly) begin
					if (i_mret) begin
						m_pc_if <= i_mepc;
					end else if (i_sret) begin
						m_pc_if <= i_sepc;
					end else begin
						m_pc_if <= i_jmp_adr;
					end
				end else begin
					m_pc_if <= m_pc_if + 30'd1;
				end
			end
			m_trap_dly  <= m_trap;
			m_post_jump <= m_jump_cmd;
			if (i_rst_pipe) begin
				m_pc_id <= '0;
				m_flush <= 1'b1;
			end else if (!i_stall) begin
				m_pc_id <= m_pc_if;
				m_flush <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		edge_stall <= i_stall;
		edge_flush <= i_rst_pipe;
	end

	// outputs are settled by the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			assert (o_pc_data == {m_pc_if, 2'b00})
				else value_error($sformatf("pc_data %h, expected %h", o_pc_data, {m_pc_if, 2'b00}));
			assert (o_pc_id == m_pc_id)
				else value_error($sformatf("pc_id %h, expected %h", o_pc_id, m_pc_id));
			assert (o_post_jump == m_post_jump)
				else value_error($sformatf("post_jump %b, expected %b", o_post_jump, m_post_jump));
			if (inst_on) begin
				assert (o_inst_id == exp_inst)
					else value_error($sformatf("inst_id %h at pc_id %h, expected %h",
						o_inst_id, o_pc_id, exp_inst));
				if (edge_stall && !edge_flush && have_prev) begin
					assert (o_pc_id == prev_pc_id && o_inst_id == prev_inst)
						else value_error("decode pair moved during a stall");
				end
				prev_pc_id = o_pc_id;
				prev_inst  = o_inst_id;
				have_prev  = 1'b1;
			end
		end
	end

	task automatic wait_pc_id(input pc_t target, input int limit, input string what);
		int   n;
		logic found;
		n = 0;
		found = 1'b0;
		while (!found && n < limit) begin
			@(negedge clk);
			found = (o_pc_id == target);
			n++;
		end
		if (!found) begin
			timeout_error(what);
		end
	endtask

	task automatic write_program();
		for (int i = 0; i < IDEPTH; i++) begin
			@(posedge clk);
			i_ram_wen   <= 1'b1;
			i_ram_wadr  <= iaddr_t'(i);
			i_ram_wdata <= pattern_word(iaddr_t'(i));
		end
		@(posedge clk);
		i_ram_wen <= 1'b0;
	endtask

	// monitor read, data is due one clock after the address
	task automatic read_back(input iaddr_t adr);
		@(posedge clk);
		i_read_sel <= 1'b1;
		i_ram_radr <= adr;
		@(posedge clk);
		@(negedge clk);
		assert (o_ram_rdata == pattern_word(adr))
			else value_error($sformatf("monitor read at %h gave %h", adr, o_ram_rdata));
	endtask

	task automatic run_cycles(input int n, input logic random_stall);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			i_stall <= random_stall && (($urandom % 3) == 0);
		end
		@(posedge clk);
		i_stall <= 1'b0;
	endtask

	// one-cycle redirect request
	task automatic pulse_redirect(input logic jmp, input logic mret, input logic sret,
			input logic ecall, input logic intr, input logic exc, input pc_t jadr);
		@(posedge clk);
		i_jmp_cond  <= jmp;
		i_jmp_adr   <= jadr;
		i_mret      <= mret;
		i_sret      <= sret;
		i_ecall     <= ecall;
		i_interrupt <= intr;
		i_exception <= exc;
		@(posedge clk);
		i_jmp_cond  <= 1'b0;
		i_mret      <= 1'b0;
		i_sret      <= 1'b0;
		i_ecall     <= 1'b0;
		i_interrupt <= 1'b0;
		i_exception <= 1'b0;
	endtask

	task automatic expect_flushed(input int n);
		repeat (n) begin
			@(negedge clk);
			assert (o_inst_id == NOP_INST && o_pc_id == '0)
				else value_error($sformatf("flush gave %h at pc_id %h", o_inst_id, o_pc_id));
		end
	endtask

	initial begin
		rst_n       = 1'b0;
		i_stall     = 1'b0;
		i_rst_pipe  = 1'b0;
		i_jmp_cond  = 1'b0;
		i_jmp_adr   = '0;
		i_ecall     = 1'b0;
		i_interrupt = 1'b0;
		i_exception = 1'b0;
		i_mret      = 1'b0;
		i_sret      = 1'b0;
		i_mtvec     = MTVEC;
		i_mepc      = MEPC;
		i_sepc      = SEPC;
		i_pc_start  = 1'b0;
		i_start_adr = '0;
		i_ram_radr  = '0;
		i_ram_wadr  = '0;
		i_ram_wdata = '0;
		i_ram_wen   = 1'b0;
		i_read_sel  = 1'b0;
		void'($urandom(32'hcf83eb60));
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (o_inst_id == NOP_INST && o_pc_id == '0)
			else value_error("decode pair after reset is not a NOP at pc 0");

		write_program();
		read_back(iaddr_t'(0));
		read_back(iaddr_t'(IDEPTH - 1));
		repeat (16) read_back(iaddr_t'($urandom));

		@(posedge clk);
		i_read_sel  <= 1'b0;
		i_pc_start  <= 1'b1;
		i_start_adr <= START_PC;
		@(posedge clk);
		i_pc_start <= 1'b0;
		wait_pc_id(START_PC, 8, "the start address on pc_id");
		@(posedge clk);
		inst_on = 1'b1;

		run_cycles(40, 1'b0);    // plain sequential fetch
		run_cycles(200, 1'b1);

		// single redirects, then the priority cases
		pulse_redirect(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, JMP_A);
		wait_pc_id(JMP_A, 6, "the jump target");
		run_cycles(5, 1'b0);
		pulse_redirect(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, JMP_A);
		wait_pc_id(MEPC, 6, "the mret target");
		run_cycles(5, 1'b0);
		pulse_redirect(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, JMP_A);
		wait_pc_id(SEPC, 6, "the sret target");
		run_cycles(5, 1'b0);
		pulse_redirect(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, JMP_C);
		wait_pc_id(SEPC, 6, "sret over jump");
		pulse_redirect(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, JMP_C);
		wait_pc_id(MEPC, 6, "mret over sret and jump");
		pulse_redirect(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, JMP_C);
		wait_pc_id(MTVEC, 6, "ecall over mret and jump");
		pulse_redirect(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, JMP_B);
		wait_pc_id(JMP_B, 6, "a jump above the RAM size");
		run_cycles(30, 1'b1);
		pulse_redirect(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, JMP_A);
		wait_pc_id(MTVEC, 6, "the interrupt vector");
		run_cycles(5, 1'b0);

		// jump right behind an exception must be dropped
		@(posedge clk);
		i_exception <= 1'b1;
		@(posedge clk);
		i_exception <= 1'b0;
		i_jmp_cond  <= 1'b1;
		i_jmp_adr   <= JMP_C;
		@(posedge clk);
		i_jmp_cond <= 1'b0;
		wait_pc_id(MTVEC, 6, "the exception vector");
		@(negedge clk);
		assert (o_pc_id == MTVEC + 30'd1)
			else value_error($sformatf("jump in trap shadow taken, pc_id %h", o_pc_id));

		// flush alone, then a flush inside a stall
		@(posedge clk);
		i_rst_pipe <= 1'b1;
		@(posedge clk);
		i_rst_pipe <= 1'b0;
		expect_flushed(1);
		run_cycles(10, 1'b0);
		@(posedge clk);
		i_stall    <= 1'b1;
		i_rst_pipe <= 1'b1;
		@(posedge clk);
		i_rst_pipe <= 1'b0;
		expect_flushed(3);
		@(posedge clk);
		i_stall <= 1'b0;
		run_cycles(60, 1'b1);

		@(negedge clk);
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== all.f ====
logic/fetch_pkg.sv
logic/pc_sequencer.sv
logic/inst_ram.sv
logic/fetch_hold.sv
logic/fetch_unit.sv
sim/tb_fetch_unit.sv

// ==== Makefile ====
TOP = tb_fetch_unit

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
